//--- adc_pkg.sv
package adc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // spi timing
    ////////////////////////////////////////////////////////////////////////////

    // system clocks per sclk half period
    localparam int sclk_half = 8;
    localparam int div_w = $clog2(sclk_half);
    localparam logic [div_w-1:0] div_last = div_w'(sclk_half - 1);

    // idle clocks between two frames
    localparam int frame_gap = 800;
    localparam int gap_w = $clog2(frame_gap);
    localparam logic [gap_w-1:0] gap_load = gap_w'(frame_gap - 1);

    // frame sizes
    localparam int max_frame_bits = 32;
    localparam int frame_len_w = 6;
    localparam int sample_w = 24;

    ////////////////////////////////////////////////////////////////////////////
    // adc commands and configuration
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] cmd_rd_status = 8'h40;
    localparam logic [7:0] cmd_rd_data = 8'h42;
    // command byte plus status byte
    localparam logic [frame_len_w-1:0] status_frame_bits = 6'd16;
    // command byte plus 24 bit conversion result
    localparam logic [frame_len_w-1:0] data_frame_bits = 6'd32;

    localparam int cfg_count = 5;
    localparam int cfg_idx_w = $clog2(cfg_count);
    localparam logic [cfg_idx_w-1:0] cfg_last = cfg_idx_w'(cfg_count - 1);

    // register writes, left aligned, shifted out msb first
    localparam logic [max_frame_bits-1:0] cfg_words [cfg_count] = '{
        32'h0100_8000,
        32'h0300_18C0,
        32'h0981_AE00,
        32'h1909_E100,
        32'h2106_03C0
    };
    localparam logic [frame_len_w-1:0] cfg_bits [cfg_count] = '{
        6'd24, 6'd32, 6'd24, 6'd24, 6'd32
    };

    // rdy_n flag inside the status byte
    localparam int ready_n_bit = 7;

    typedef enum logic [2:0] {
        idle, cfg_gap, cfg_xfer, poll_gap, poll_xfer, data_gap, data_xfer, done_hold
    } seq_state_t;

endpackage

//--- spi_frame_engine.sv
`timescale 1ns/10ps

module spi_frame_engine (
    input  logic                               PL_clk,
    input  logic                               rst,
    input  logic                               xfer_go,
    input  logic [adc_pkg::max_frame_bits-1:0] xfer_word,
    input  logic [adc_pkg::frame_len_w-1:0]    xfer_bits,
    input  logic                               miso,
    output logic                               xfer_busy,
    output logic                               xfer_end,
    output logic [adc_pkg::max_frame_bits-1:0] rx_word,
    output logic                               cs_n,
    output logic                               sclk,
    output logic                               mosi
);

    logic [adc_pkg::div_w-1:0]          div_cnt;
    // sclk edges still to come, two per bit
    logic [adc_pkg::frame_len_w:0]      edge_left;
    logic [adc_pkg::max_frame_bits-1:0] tx_sh;
    logic                               launch;
    logic                               tick;
    logic                               fall_tick;
    logic                               rise_tick;

    assign launch = xfer_go && !xfer_busy;
    assign tick = xfer_busy && (edge_left != '0) && (div_cnt == adc_pkg::div_last);
    // mode 3: idle high, shift on falling, sample on rising
    assign fall_tick = tick && sclk;
    assign rise_tick = tick && !sclk;

    ////////////////////////////////////////////////////////////////////////////
    // frame control and pins
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            xfer_busy <= 1'b0;
            xfer_end <= 1'b0;
            cs_n <= 1'b1;
            sclk <= 1'b1;
            mosi <= 1'b0;
            div_cnt <= '0;
            edge_left <= '0;
        end else begin
            xfer_end <= 1'b0;
            if (launch) begin
                xfer_busy <= 1'b1;
                cs_n <= 1'b0;
                div_cnt <= '0;
                edge_left <= {xfer_bits, 1'b0};
            end else if (xfer_busy && (edge_left != '0)) begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) begin
                    sclk <= ~sclk;
                    edge_left <= edge_left - 1'b1;
                end
                // next bit goes out on the falling edge
                if (fall_tick)
                    mosi <= tx_sh[adc_pkg::max_frame_bits-1];
            end else if (xfer_busy) begin
                // one clock of hold after the last rising edge
                xfer_busy <= 1'b0;
                xfer_end <= 1'b1;
                cs_n <= 1'b1;
                mosi <= 1'b0;
            end
        end
    end

    // shift registers, rx fills from the lsb so short replies sit low
    always_ff @(posedge PL_clk) begin
        if (launch) begin
            tx_sh <= xfer_word;
            rx_word <= '0;
        end else begin
            if (fall_tick)
                tx_sh <= {tx_sh[adc_pkg::max_frame_bits-2:0], 1'b0};
            if (rise_tick)
                rx_word <= {rx_word[adc_pkg::max_frame_bits-2:0], miso};
        end
    end

endmodule

//--- frame_gap_timer.sv
`timescale 1ns/10ps

module frame_gap_timer (
    input  logic PL_clk,
    input  logic rst,
    input  logic gap_go,
    output logic gap_end
);

    // remaining clocks of the gap, zero when idle
    logic [adc_pkg::gap_w-1:0] gap_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // gap counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            gap_cnt <= '0;
            gap_end <= 1'b0;
        end else if (gap_go) begin
            // a go while running simply restarts the gap
            gap_cnt <= adc_pkg::gap_load;
            gap_end <= 1'b0;
        end else begin
            if (gap_cnt != '0)
                gap_cnt <= gap_cnt - 1'b1;
            // end pulse lands frame_gap clocks after the go pulse
            gap_end <= (gap_cnt == 1);
        end
    end

endmodule

//--- sample_capture.sv
`timescale 1ns/10ps

module sample_capture (
    input  logic                               PL_clk,
    input  logic                               rst,
    input  logic                               xfer_end,
    input  logic [adc_pkg::max_frame_bits-1:0] rx_word,
    input  logic                               cap_status,
    input  logic                               cap_data,
    output logic                               ready,
    output logic [adc_pkg::sample_w-1:0]       sample,
    output logic                               sample_valid
);

    logic status_done;
    logic data_done;

    // frame kind is held by the controller for the whole transfer
    assign status_done = xfer_end && cap_status;
    assign data_done = xfer_end && cap_data;

    // ready flag and valid strobe
    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            ready <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= data_done;
            // rdy_n low means a conversion is waiting
            if (status_done)
                ready <= !rx_word[adc_pkg::ready_n_bit];
            else if (data_done)
                ready <= 1'b0;
        end
    end

    // result sits in the low bits after the command byte
    always_ff @(posedge PL_clk) begin
        if (data_done)
            sample <= rx_word[adc_pkg::sample_w-1:0];
    end

endmodule

//--- adc_seq_ctrl.sv
`timescale 1ns/10ps

module adc_seq_ctrl (
    input  logic                               PL_clk,
    input  logic                               rst,
    input  logic                               start,
    input  logic                               xfer_busy,
    input  logic                               xfer_end,
    input  logic                               gap_end,
    input  logic                               ready,
    input  logic                               sample_valid,
    output logic                               xfer_go,
    output logic [adc_pkg::max_frame_bits-1:0] xfer_word,
    output logic [adc_pkg::frame_len_w-1:0]    xfer_bits,
    output logic                               gap_go,
    output logic                               cap_status,
    output logic                               cap_data,
    output logic                               done
);

    adc_pkg::seq_state_t              state;
    logic [adc_pkg::cfg_idx_w-1:0]    cfg_idx;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            state <= adc_pkg::idle;
            cfg_idx <= '0;
            xfer_go <= 1'b0;
            gap_go <= 1'b0;
        end else begin
            xfer_go <= 1'b0;
            gap_go <= 1'b0;
            if (!start) begin
                // abort from anywhere, engine finishes its frame alone
                state <= adc_pkg::idle;
                cfg_idx <= '0;
            end else begin
                case (state)
                    adc_pkg::idle: if (!xfer_busy) begin
                        state <= adc_pkg::cfg_gap;
                        cfg_idx <= '0;
                        gap_go <= 1'b1;
                    end
                    adc_pkg::cfg_gap: if (gap_end) begin
                        state <= adc_pkg::cfg_xfer;
                        xfer_go <= 1'b1;
                    end
                    adc_pkg::cfg_xfer: if (xfer_end) begin
                        gap_go <= 1'b1;
                        if (cfg_idx == adc_pkg::cfg_last) begin
                            state <= adc_pkg::poll_gap;
                        end else begin
                            cfg_idx <= cfg_idx + 1'b1;
                            state <= adc_pkg::cfg_gap;
                        end
                    end
                    adc_pkg::poll_gap: if (gap_end) begin
                        state <= adc_pkg::poll_xfer;
                        xfer_go <= 1'b1;
                    end
                    // ready is only valid the clock after the status frame
                    adc_pkg::poll_xfer: if (xfer_end) begin
                        state <= adc_pkg::data_gap;
                        gap_go <= 1'b1;
                    end
                    adc_pkg::data_gap: begin
                        // still busy, same gap then another status read
                        if (!ready)
                            state <= adc_pkg::poll_gap;
                        else if (gap_end) begin
                            state <= adc_pkg::data_xfer;
                            xfer_go <= 1'b1;
                        end
                    end
                    adc_pkg::data_xfer: if (sample_valid)
                        state <= adc_pkg::done_hold;
                    // single shot, wait here for start to drop
                    default: state <= adc_pkg::done_hold;
                endcase
            end
        end
    end

    // frame contents follow the phase
    always_comb begin
        case (state)
            adc_pkg::cfg_gap, adc_pkg::cfg_xfer: begin
                xfer_word = adc_pkg::cfg_words[cfg_idx];
                xfer_bits = adc_pkg::cfg_bits[cfg_idx];
            end
            adc_pkg::data_gap, adc_pkg::data_xfer: begin
                xfer_word = {adc_pkg::cmd_rd_data, 24'h0};
                xfer_bits = adc_pkg::data_frame_bits;
            end
            default: begin
                xfer_word = {adc_pkg::cmd_rd_status, 24'h0};
                xfer_bits = adc_pkg::status_frame_bits;
            end
        endcase
    end

    assign cap_status = (state == adc_pkg::poll_xfer);
    assign cap_data = (state == adc_pkg::data_xfer);
    // done comes up together with the sample strobe
    assign done = (state == adc_pkg::done_hold)
                  || ((state == adc_pkg::data_xfer) && sample_valid);

endmodule

//--- adc_ctrl_top.sv
`timescale 1ns/10ps

module adc_ctrl_top (
    input  logic                         PL_clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         miso,
    output logic                         cs_n,
    output logic                         sclk,
    output logic                         mosi,
    output logic [adc_pkg::sample_w-1:0] sample,
    output logic                         sample_valid,
    output logic                         done
);

    // controller to frame engine
    logic                               xfer_go;
    logic [adc_pkg::max_frame_bits-1:0] xfer_word;
    logic [adc_pkg::frame_len_w-1:0]    xfer_bits;
    logic                               xfer_busy;
    logic                               xfer_end;
    logic [adc_pkg::max_frame_bits-1:0] rx_word;
    // gap timer handshake
    logic                               gap_go;
    logic                               gap_end;
    // capture side
    logic                               cap_status;
    logic                               cap_data;
    logic                               ready;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    adc_seq_ctrl u_seq (
        .PL_clk(PL_clk), .rst(rst), .start(start),
        .xfer_busy(xfer_busy), .xfer_end(xfer_end), .gap_end(gap_end),
        .ready(ready), .sample_valid(sample_valid),
        .xfer_go(xfer_go), .xfer_word(xfer_word), .xfer_bits(xfer_bits),
        .gap_go(gap_go), .cap_status(cap_status), .cap_data(cap_data),
        .done(done)
    );

    frame_gap_timer u_gap (
        .PL_clk(PL_clk), .rst(rst), .gap_go(gap_go), .gap_end(gap_end)
    );

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    spi_frame_engine u_spi (
        .PL_clk(PL_clk), .rst(rst), .xfer_go(xfer_go),
        .xfer_word(xfer_word), .xfer_bits(xfer_bits), .miso(miso),
        .xfer_busy(xfer_busy), .xfer_end(xfer_end), .rx_word(rx_word),
        .cs_n(cs_n), .sclk(sclk), .mosi(mosi)
    );

    sample_capture u_cap (
        .PL_clk(PL_clk), .rst(rst), .xfer_end(xfer_end), .rx_word(rx_word),
        .cap_status(cap_status), .cap_data(cap_data),
        .ready(ready), .sample(sample), .sample_valid(sample_valid)
    );

endmodule

//--- tb_sva.sv
`timescale 1ns/10ps

module tb_sva (
    input logic                            PL_clk,
    input logic                            rst,
    input logic                            start,
    input logic                            cs_n,
    input logic                            sclk,
    input logic                            done,
    input logic                            sample_valid,
    input logic                            xfer_go,
    input logic                            xfer_busy,
    input logic [adc_pkg::frame_len_w-1:0] xfer_bits
);

    logic [adc_pkg::frame_len_w-1:0] bits_q;
    // sclk edges inside the current cs_n window
    logic [adc_pkg::frame_len_w:0]   edge_cnt;
    logic                            sclk_q;
    int                              fail_cnt = 0;

    always_ff @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            bits_q <= '0;
            edge_cnt <= '0;
            sclk_q <= 1'b1;
        end else begin
            sclk_q <= sclk;
            if (xfer_go && !xfer_busy)
                bits_q <= xfer_bits;
            if (cs_n)
                edge_cnt <= '0;
            else if (sclk != sclk_q)
                edge_cnt <= edge_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pins and handshake
    ////////////////////////////////////////////////////////////////////////////

    // mode 3 idle levels between frames
    a_idle_pins: assert property (@(posedge PL_clk) disable iff (!rst)
        !xfer_busy |-> cs_n && sclk)
        else begin $error("spi pins not idle outside a frame"); fail_cnt++; end

    // two sclk edges per bit
    a_edge_count: assert property (@(posedge PL_clk) disable iff (!rst)
        $rose(cs_n) |-> edge_cnt == {bits_q, 1'b0})
        else begin $error("wrong number of sclk edges in a frame"); fail_cnt++; end

    a_valid_pulse: assert property (@(posedge PL_clk) disable iff (!rst)
        sample_valid |=> !sample_valid)
        else begin $error("sample_valid longer than one clock"); fail_cnt++; end

    a_done_rise: assert property (@(posedge PL_clk) disable iff (!rst)
        $rose(done) |-> sample_valid)
        else begin $error("done rose without sample_valid"); fail_cnt++; end

    a_quiet_done: assert property (@(posedge PL_clk) disable iff (!rst)
        done |-> cs_n)
        else begin $error("spi frame while done is high"); fail_cnt++; end

    a_done_hold: assert property (@(posedge PL_clk) disable iff (!rst)
        done && start |=> done)
        else begin $error("done dropped while start is high"); fail_cnt++; end

    a_done_clear: assert property (@(posedge PL_clk) disable iff (!rst)
        !start |=> !done)
        else begin $error("done still high after start fell"); fail_cnt++; end

endmodule

bind adc_ctrl_top tb_sva u_sva (
    .PL_clk(PL_clk), .rst(rst), .start(start), .cs_n(cs_n), .sclk(sclk),
    .done(done), .sample_valid(sample_valid), .xfer_go(xfer_go),
    .xfer_busy(xfer_busy), .xfer_bits(xfer_bits)
);

//--- adc_spi_model.sv
`timescale 1ns/10ps

module adc_spi_model (
    input  logic                         cs_n,
    input  logic                         sclk,
    input  logic                         mosi,
    input  logic [2:0]                   busy_polls,
    input  logic [adc_pkg::sample_w-1:0] reply_sample,
    output logic                         miso,
    output int                           errors
);

    // bits seen so far, right aligned like the dut receiver
    logic [adc_pkg::max_frame_bits-1:0] rx;
    logic [adc_pkg::max_frame_bits-1:0] exp_word;
    // reply bits, shifted out msb first after the command byte
    logic [adc_pkg::sample_w-1:0]       reply;
    logic [7:0]                         cmd;
    logic [7:0]                         stat;
    logic [adc_pkg::cfg_idx_w-1:0]      cfg_seen;
    logic                               cfg_done;
    int                                 nbits;
    int                                 exp_bits;
    int                                 status_seen;

    ////////////////////////////////////////////////////////////////////////////
    // frame decode at cs_n rise
    ////////////////////////////////////////////////////////////////////////////

    task automatic end_frame();
        if (!cfg_done) begin
            // config writes come first and in table order
            exp_bits = int'(adc_pkg::cfg_bits[cfg_seen]);
            exp_word = adc_pkg::cfg_words[cfg_seen] >> (adc_pkg::max_frame_bits - exp_bits);
            if (nbits != exp_bits || rx != exp_word) begin
                $display("error %0t: config write %0d is %0d bits %h, expected %0d bits %h",
                         $time, cfg_seen, nbits, rx, exp_bits, exp_word);
                errors++;
            end
            if (cfg_seen == adc_pkg::cfg_last)
                cfg_done = 1'b1;
            else
                cfg_seen = cfg_seen + 1'b1;
        end else if (cmd == adc_pkg::cmd_rd_status && nbits == 16) begin
            status_seen++;
            if (status_seen > int'(busy_polls) + 1) begin
                $display("error %0t: status poll %0d after ready was shown", $time, status_seen);
                errors++;
            end
        end else if (cmd == adc_pkg::cmd_rd_data && nbits == 32) begin
            if (status_seen != int'(busy_polls) + 1) begin
                $display("error %0t: data read after %0d polls, expected %0d",
                         $time, status_seen, int'(busy_polls) + 1);
                errors++;
            end
            // acquisition over, next frame starts a new config run
            cfg_done = 1'b0;
            cfg_seen = '0;
            status_seen = 0;
        end else begin
            $display("error %0t: unexpected frame of %0d bits, %h", $time, nbits, rx);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // mode 3 slave
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        miso = 1'b0;
        errors = 0;
        cfg_seen = '0;
        cfg_done = 1'b0;
        status_seen = 0;
        forever begin
            @(negedge cs_n);
            rx = '0;
            nbits = 0;
            reply = '0;
            cmd = '0;
            forever begin
                @(negedge sclk or posedge cs_n);
                if (cs_n)
                    break;
                // drive on falling sclk
                miso = reply[adc_pkg::sample_w-1];
                reply = {reply[adc_pkg::sample_w-2:0], 1'b0};
                // sample on rising sclk
                @(posedge sclk);
                rx = {rx[adc_pkg::max_frame_bits-2:0], mosi};
                nbits++;
                if (nbits == 8) begin
                    cmd = rx[7:0];
                    // busy for the first busy_polls status reads
                    stat = 8'h05;
                    stat[adc_pkg::ready_n_bit] = (status_seen < int'(busy_polls));
                    if (cmd == adc_pkg::cmd_rd_status)
                        reply = {stat, 16'h0};
                    else if (cmd == adc_pkg::cmd_rd_data)
                        reply = reply_sample;
                end
            end
            miso = 1'b0;
            end_frame();
        end
    end

endmodule

//--- tb_checker.sv
`timescale 1ns/10ps

module tb_checker (
    input  logic                         PL_clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         cs_n,
    input  logic                         done,
    input  logic                         sample_valid,
    input  logic [adc_pkg::sample_w-1:0] sample,
    input  logic [adc_pkg::sample_w-1:0] exp_sample,
    output int                           errors
);

    logic start_q;
    logic done_q;
    // valid pulses in the current acquisition
    int   valid_cnt;

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare on rising edge, inputs settled half a cycle earlier
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge PL_clk or negedge rst) begin
        if (!rst) begin
            start_q = 1'b0;
            done_q = 1'b0;
            valid_cnt = 0;
            errors = 0;
        end else begin
            if (sample_valid) begin
                valid_cnt++;
                if (sample !== exp_sample)
                    report_error($sformatf("sample %h, expected %h", sample, exp_sample));
                if (!done)
                    report_error("done not raised with sample_valid");
            end
            if (done && !done_q && !sample_valid)
                report_error("done rose without a sample");
            if (start && done_q && !done)
                report_error("done dropped while start is high");
            // single shot, bus stays quiet once done
            if (done && !cs_n)
                report_error("spi frame while done is high");
            // one clock of slack after start falls
            if (!start && !start_q && (done || sample_valid))
                report_error("done or sample_valid high with start low");
            if (!start && start_q) begin
                if (valid_cnt != 1)
                    report_error($sformatf("%0d sample_valid pulses in one acquisition",
                                           valid_cnt));
                valid_cnt = 0;
            end
            start_q = start;
            done_q = done;
        end
    end

endmodule

//--- tb_adc_ctrl.sv
`timescale 1ns/10ps

module tb_adc_ctrl;

    localparam int rows = 4;
    localparam int max_busy = 4;
    // worst case frame plus its gap
    localparam int frame_clocks = adc_pkg::frame_gap
                                  + 2 * adc_pkg::sclk_half * adc_pkg::max_frame_bits + 2;
    localparam int cycle_limit = rows * (9 + max_busy + 1) * frame_clocks + rows * 3000;

    logic                         PL_clk = 1'b0;
    logic                         rst;
    logic                         start;
    logic                         miso;
    logic                         cs_n;
    logic                         sclk;
    logic                         mosi;
    logic                         sample_valid;
    logic                         done;
    logic [adc_pkg::sample_w-1:0] sample;
    // current row, shared by model and checker
    logic [2:0]                   busy_polls;
    logic [adc_pkg::sample_w-1:0] reply_sample;
    logic [2:0]                   busy_tab [rows];
    logic [adc_pkg::sample_w-1:0] sample_tab [rows];
    int                           model_errors;
    int                           check_errors;
    int                           sva_errors;
    int                           cycles = 0;

    always #5 PL_clk = ~PL_clk;

    adc_ctrl_top u_adc_ctrl_top (
        .PL_clk(PL_clk), .rst(rst), .start(start), .miso(miso),
        .cs_n(cs_n), .sclk(sclk), .mosi(mosi),
        .sample(sample), .sample_valid(sample_valid), .done(done)
    );

    adc_spi_model u_adc_model (
        .cs_n(cs_n), .sclk(sclk), .mosi(mosi), .busy_polls(busy_polls),
        .reply_sample(reply_sample), .miso(miso), .errors(model_errors)
    );

    tb_checker u_checker (
        .PL_clk(PL_clk), .rst(rst), .start(start), .cs_n(cs_n), .done(done),
        .sample_valid(sample_valid), .sample(sample), .exp_sample(reply_sample),
        .errors(check_errors)
    );

    // run limit
    always @(posedge PL_clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: no end of test after %0d clocks", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus, driven on falling edges
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(87216));
        rst = 1'b0;
        start = 1'b0;
        busy_polls = '0;
        reply_sample = '0;
        busy_tab = '{3'd0, 3'd1, 3'd3, 3'd0};
        sample_tab = '{24'h123456, 24'hA5C3F0, 24'h800001, 24'h000000};
        busy_tab[3] = 3'($urandom_range(max_busy, 0));
        sample_tab[3] = 24'($urandom());
        repeat (2) @(negedge PL_clk);
        rst = 1'b1;
        repeat (4) @(negedge PL_clk);
        for (int r = 0; r < rows; r++) begin
            busy_polls = busy_tab[r];
            reply_sample = sample_tab[r];
            start = 1'b1;
            while (!done)
                @(negedge PL_clk);
            // bus must stay quiet while start is held
            repeat (2000) @(negedge PL_clk);
            start = 1'b0;
            repeat (20) @(negedge PL_clk);
        end
        sva_errors = u_adc_ctrl_top.u_sva.fail_cnt;
        $display("errors: %0d checker, %0d spi model, %0d assertion",
                 check_errors, model_errors, sva_errors);
        if (check_errors + model_errors + sva_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sim.f
adc_pkg.sv
spi_frame_engine.sv
frame_gap_timer.sv
sample_capture.sv
adc_seq_ctrl.sv
adc_ctrl_top.sv
tb_sva.sv
adc_spi_model.sv
tb_checker.sv
tb_adc_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_adc_ctrl
FLIST     := sim.f
OBJDIR    := obj_dir
LOG       := sim.log
# keep running past the first assertion so the closing line is printed
SIMFLAGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
